//--- source/edge_fetch_pkg.sv
`default_nettype none

package edge_fetch_pkg;

	// Memory geometry
	parameter int EDGE_BYTES = 4;
	parameter int LINE_BYTES = 16;
	parameter int LINE_EDGES = LINE_BYTES / EDGE_BYTES;

	parameter int ADDR_W = 32;
	parameter int VID_W  = 32;
	parameter int CNT_W  = 16;

	// Word position inside a line, and edges taken from one line
	parameter int SLOT_W = $clog2(LINE_EDGES);
	parameter int LCNT_W = $clog2(LINE_EDGES + 1);

	typedef enum logic {
		READ_NO_ALLOC = 1'b0,
		READ_SHARED   = 1'b1
	} read_opcode_e;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		CALC,
		ISSUE,
		WAIT_LINE,
		DRAIN
	} seq_state_e;

	typedef struct packed {
		logic        sel;
		logic        enable;
		logic        write;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ready;
		logic        slverr;
	} apb_rsp_t;

	typedef struct packed {
		logic [VID_W-1:0] id;
		logic [VID_W-1:0] edge_idx;
		logic [CNT_W-1:0] degree;
	} vertex_job_t;

	typedef struct packed {
		logic [ADDR_W-1:0] address;
		read_opcode_e      opcode;
		logic [SLOT_W-1:0] slot;
		logic [LCNT_W-1:0] count;
	} read_cmd_t;

	// Word 0 of data holds the edge at the lowest address of the line
	typedef struct packed {
		logic                             valid;
		logic [LINE_EDGES-1:0][VID_W-1:0] data;
		logic [SLOT_W-1:0]                slot;
		logic [LCNT_W-1:0]                count;
	} read_rsp_t;

	typedef struct packed {
		logic [VID_W-1:0] src;
		logic [VID_W-1:0] dest;
		logic [CNT_W-1:0] seq;
	} edge_job_t;

	typedef struct packed {
		logic              enable;
		logic              cache_hint;
		logic [ADDR_W-1:0] base;
	} fetch_cfg_t;

endpackage

`default_nettype wire

//--- source/edge_fetch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module edge_fetch_regs
	import edge_fetch_pkg::*;
(
	input  wire logic     clock,
	input  wire logic     rstn,
	input  wire apb_req_t apb_req,
	output apb_rsp_t      apb_rsp,
	input  wire logic     busy,
	input  wire logic     edge_emitted,
	output fetch_cfg_t    cfg
);

	localparam logic [7:0] ADDR_CTRL   = 8'h00;
	localparam logic [7:0] ADDR_BASE   = 8'h04;
	localparam logic [7:0] ADDR_COUNT  = 8'h08;
	localparam logic [7:0] ADDR_STATUS = 8'h0C;

	logic              access;
	logic              wr_en;
	logic              ctrl_enable;
	logic              ctrl_hint;
	logic [ADDR_W-1:0] base_q;
	logic [31:0]       edge_count;

	// Access phase of a zero wait state transfer
	assign access = apb_req.sel && apb_req.enable;
	assign wr_en  = access && apb_req.write;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ctrl_enable <= 1'b0;
			ctrl_hint   <= 1'b0;
			base_q      <= '0;
		end else if (wr_en) begin
			case (apb_req.addr)
				ADDR_CTRL: begin
					ctrl_enable <= apb_req.wdata[0];
					ctrl_hint   <= apb_req.wdata[1];
				end
				ADDR_BASE: begin
					base_q <= apb_req.wdata[ADDR_W-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	// Emitted edge total, a write of any value clears it
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_count <= '0;
		end else if (wr_en && (apb_req.addr == ADDR_COUNT)) begin
			edge_count <= '0;
		end else if (edge_emitted) begin
			edge_count <= edge_count + 32'd1;
		end
	end

	////////////////////////////////////////
	// Read path
	////////////////////////////////////////

	always_comb begin
		apb_rsp.rdata  = '0;
		apb_rsp.ready  = 1'b1;
		apb_rsp.slverr = 1'b0;
		if (access) begin
			case (apb_req.addr)
				ADDR_CTRL:   apb_rsp.rdata = {30'd0, ctrl_hint, ctrl_enable};
				ADDR_BASE:   apb_rsp.rdata = 32'(base_q);
				ADDR_COUNT:  apb_rsp.rdata = edge_count;
				ADDR_STATUS: apb_rsp.rdata = {31'd0, busy};
				default:     apb_rsp.slverr = 1'b1;
			endcase
		end
	end

	assign cfg = '{enable: ctrl_enable, cache_hint: ctrl_hint, base: base_q};

	// Every access phase comes out of a selected setup phase
	apb_enable_sel: assert property (@(posedge clock) disable iff (!rstn)
		apb_req.enable |-> apb_req.sel && $past(apb_req.sel));

endmodule

`default_nettype wire

//--- source/edge_read_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module edge_read_sequencer
	import edge_fetch_pkg::*;
(
	input  wire logic        clock,
	input  wire logic        rstn,
	input  wire fetch_cfg_t  cfg,
	input  wire logic        vertex_valid,
	input  wire vertex_job_t vertex_job,
	output logic             vertex_ready,
	output logic             cmd_valid,
	output read_cmd_t        cmd,
	input  wire logic        cmd_ready,
	output read_cmd_t        line_cmd,
	output logic [VID_W-1:0] vertex_id,
	input  wire logic        line_done,
	output logic             busy
);

	localparam int EDGE_SHIFT = $clog2(EDGE_BYTES);

	seq_state_e        state;
	seq_state_e        state_next;
	logic [VID_W-1:0]  edge_idx;
	logic [CNT_W-1:0]  remain;
	logic [ADDR_W-1:0] byte_addr;
	logic [SLOT_W-1:0] slot_c;
	logic [LCNT_W-1:0] room_c;
	logic [LCNT_W-1:0] count_c;
	logic              vertex_take;
	logic              cmd_take;

	assign vertex_ready = (state == IDLE) && cfg.enable;
	assign vertex_take  = vertex_valid && vertex_ready;
	assign cmd_valid    = (state == ISSUE);
	assign cmd_take     = cmd_valid && cmd_ready;
	assign busy         = (state != IDLE);

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (vertex_take) begin
					state_next = LOAD;
				end
			end
			LOAD: begin
				// Degree 0 ends here without a command
				state_next = (remain == '0) ? IDLE : CALC;
			end
			CALC: begin
				state_next = ISSUE;
			end
			ISSUE: begin
				if (cmd_ready) begin
					state_next = WAIT_LINE;
				end
			end
			WAIT_LINE: begin
				if (line_done) begin
					state_next = (remain == '0) ? DRAIN : CALC;
				end
			end
			DRAIN: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// Command rule
	////////////////////////////////////////

	// Partial first line when the index is not line aligned
	assign slot_c    = edge_idx[SLOT_W-1:0];
	assign room_c    = LCNT_W'(LINE_EDGES) - LCNT_W'(slot_c);
	assign count_c   = (remain < CNT_W'(room_c)) ? remain[LCNT_W-1:0] : room_c;
	assign byte_addr = cfg.base + (ADDR_W'(edge_idx) << EDGE_SHIFT);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= IDLE;
			edge_idx <= '0;
			remain   <= '0;
			line_cmd <= '0;
		end else begin
			state <= state_next;
			if (vertex_take) begin
				edge_idx <= vertex_job.edge_idx;
				remain   <= vertex_job.degree;
			end else if (state == CALC) begin
				edge_idx <= edge_idx + VID_W'(count_c);
				remain   <= remain - CNT_W'(count_c);
			end
			// A zero count tells the unpacker no vertex is in flight
			if (cmd_take) begin
				line_cmd <= cmd;
			end else if (state == DRAIN) begin
				line_cmd <= '0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (vertex_take) begin
			vertex_id <= vertex_job.id;
		end
		if (state == CALC) begin
			cmd.address <= byte_addr & ~ADDR_W'(LINE_BYTES - 1);
			cmd.opcode  <= cfg.cache_hint ? READ_SHARED : READ_NO_ALLOC;
			cmd.slot    <= slot_c;
			cmd.count   <= count_c;
		end
	end

	// Memory side may stall, the command must not move under it
	cmd_hold: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

//--- source/edge_line_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

module edge_line_unpacker
	import edge_fetch_pkg::*;
(
	input  wire logic             clock,
	input  wire logic             rstn,
	input  wire read_rsp_t        rsp,
	input  wire read_cmd_t        line_cmd,
	input  wire logic [VID_W-1:0] vertex_id,
	input  wire logic             fifo_full,
	output logic                  edge_push,
	output edge_job_t             edge_data,
	output logic                  line_done
);

	logic [LINE_EDGES-1:0][VID_W-1:0] line_q;
	logic [SLOT_W-1:0]                ptr;
	logic [LCNT_W-1:0]                left;
	logic [CNT_W-1:0]                 seq_num;
	logic                             vertex_idle;

	assign vertex_idle = (line_cmd.count == '0);
	assign edge_push   = (left != '0) && !fifo_full;
	assign edge_data   = '{src: vertex_id, dest: line_q[ptr], seq: seq_num};

	always_ff @(posedge clock) begin
		if (rsp.valid) begin
			line_q <= rsp.data;
		end
	end

	////////////////////////////////////////
	// Word pointer and sequence number
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ptr       <= '0;
			left      <= '0;
			seq_num   <= '0;
			line_done <= 1'b0;
		end else begin
			// Pulse follows the last word of the line
			line_done <= edge_push && (left == LCNT_W'(1));
			if (rsp.valid) begin
				ptr  <= line_cmd.slot;
				left <= line_cmd.count;
			end else if (edge_push) begin
				ptr  <= ptr + 1'b1;
				left <= left - 1'b1;
			end
			if (vertex_idle) begin
				seq_num <= '0;
			end else if (edge_push) begin
				seq_num <= seq_num + 1'b1;
			end
		end
	end

	// One read in flight, and the memory echoes the command it answers
	rsp_order: assert property (@(posedge clock) disable iff (!rstn)
		rsp.valid |-> (left == '0) && (rsp.slot == line_cmd.slot)
			&& (rsp.count == line_cmd.count));

endmodule

`default_nettype wire

//--- source/edge_job_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module edge_job_fifo
	import edge_fetch_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input  wire logic      clock,
	input  wire logic      rstn,
	input  wire logic      push,
	input  wire edge_job_t data_in,
	output logic           full,
	output logic           valid,
	output edge_job_t      data_out,
	input  wire logic      ready
);

	localparam int PTR_W   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

	edge_job_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [LEVEL_W-1:0] level;
	logic               do_push;
	logic               do_pop;

	// Wrap for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign full     = (level == LEVEL_W'(FIFO_DEPTH));
	assign valid    = (level != '0);
	assign data_out = mem[rd_ptr];
	assign do_push  = push && !full;
	assign do_pop   = valid && ready;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			if (do_push && !do_pop) begin
				level <= level + 1'b1;
			end else if (!do_push && do_pop) begin
				level <= level - 1'b1;
			end
		end
	end

	// Producer has to stall on full
	no_push_full: assert property (@(posedge clock) disable iff (!rstn)
		push |-> !full);

endmodule

`default_nettype wire

//--- source/edge_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module edge_fetch_top
	import edge_fetch_pkg::*;
#(
	parameter int FIFO_DEPTH = 8
) (
	input  wire logic        clock,
	input  wire logic        rstn,
	input  wire apb_req_t    apb_req,
	output apb_rsp_t         apb_rsp,
	input  wire logic        vertex_valid,
	input  wire vertex_job_t vertex_job,
	output logic             vertex_ready,
	output logic             cmd_valid,
	output read_cmd_t        cmd,
	input  wire logic        cmd_ready,
	input  wire read_rsp_t   rsp,
	output logic             edge_valid,
	output edge_job_t        edge_job,
	input  wire logic        edge_ready
);

	fetch_cfg_t       cfg;
	logic             busy;
	read_cmd_t        line_cmd;
	logic [VID_W-1:0] vertex_id;
	logic             line_done;
	logic             edge_push;
	edge_job_t        edge_data;
	logic             fifo_full;
	logic             edge_emitted;

	// Counted on the consumer handshake
	assign edge_emitted = edge_valid && edge_ready;

	edge_fetch_regs u_regs (
		.clock       (clock),
		.rstn        (rstn),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.busy        (busy),
		.edge_emitted(edge_emitted),
		.cfg         (cfg)
	);

	edge_read_sequencer u_sequencer (
		.clock       (clock),
		.rstn        (rstn),
		.cfg         (cfg),
		.vertex_valid(vertex_valid),
		.vertex_job  (vertex_job),
		.vertex_ready(vertex_ready),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.line_cmd    (line_cmd),
		.vertex_id   (vertex_id),
		.line_done   (line_done),
		.busy        (busy)
	);

	edge_line_unpacker u_unpacker (
		.clock    (clock),
		.rstn     (rstn),
		.rsp      (rsp),
		.line_cmd (line_cmd),
		.vertex_id(vertex_id),
		.fifo_full(fifo_full),
		.edge_push(edge_push),
		.edge_data(edge_data),
		.line_done(line_done)
	);

	edge_job_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_push),
		.data_in (edge_data),
		.full    (fifo_full),
		.valid   (edge_valid),
		.data_out(edge_job),
		.ready   (edge_ready)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	// 10 ns period
	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Reset held for the first 10 cycles
	initial begin
		rstn = 1'b0;
		repeat (10) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/edge_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module edge_fetch_tb
	import edge_fetch_pkg::*;
();

	localparam int MEM_WORDS  = 256;
	localparam int STIM_WORDS = 256;
	localparam int WAIT_LIMIT = 4000;
	localparam int POLL_LIMIT = 50;

	logic        clock;
	logic        rstn;
	apb_req_t    apb_req;
	apb_rsp_t    apb_rsp;
	logic        vertex_valid;
	vertex_job_t vertex_job;
	logic        vertex_ready;
	logic        cmd_valid;
	read_cmd_t   cmd;
	logic        cmd_ready = 1'b0;
	read_rsp_t   rsp = '0;
	logic        edge_valid;
	edge_job_t   edge_job;
	logic        edge_ready = 1'b0;

	logic [31:0] mem_model [MEM_WORDS];
	logic [31:0] stim [STIM_WORDS];
	read_cmd_t   exp_cmds [$];
	edge_job_t   exp_edges [$];
	logic [15:0] lfsr_state = 16'd5529;
	int          value_errors = 0;
	int          other_failures = 0;
	logic        timed_out = 1'b0;
	logic [31:0] ctrl_shadow = '0;
	logic [31:0] base_shadow = '0;
	int          expected_total = 0;

	// Memory model state for the one read in flight
	logic        rsp_pending = 1'b0;
	int          rsp_delay = 0;
	read_cmd_t   held_cmd;

	tb_clock_gen u_clock (
		.clock(clock),
		.rstn (rstn)
	);

	edge_fetch_top #(
		.FIFO_DEPTH(8)
	) DUT (
		.clock       (clock),
		.rstn        (rstn),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.vertex_valid(vertex_valid),
		.vertex_job  (vertex_job),
		.vertex_ready(vertex_ready),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.cmd_ready   (cmd_ready),
		.rsp         (rsp),
		.edge_valid  (edge_valid),
		.edge_job    (edge_job),
		.edge_ready  (edge_ready)
	);

	// Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic random_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		return b;
	endfunction

	function automatic int word_index(input logic [31:0] addr);
		return int'(addr[9:2]);
	endfunction

	function automatic read_rsp_t line_response(input read_cmd_t c);
		read_rsp_t r;
		r.valid = 1'b1;
		for (int w = 0; w < LINE_EDGES; w++) begin
			r.data[w] = mem_model[word_index(c.address + 32'(w * EDGE_BYTES))];
		end
		r.slot  = c.slot;
		r.count = c.count;
		return r;
	endfunction

	////////////////////////////////////////
	// APB driver
	////////////////////////////////////////

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clock);
		apb_req <= '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
		@(posedge clock);
		apb_req.enable <= 1'b1;
		@(posedge clock);
		apb_req <= '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
			output logic err);
		@(posedge clock);
		apb_req <= '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: '0};
		@(posedge clock);
		apb_req.enable <= 1'b1;
		@(posedge clock);
		data = apb_rsp.rdata;
		err  = apb_rsp.slverr;
		// Zero wait state block, ready is high in every access phase
		assert (apb_rsp.ready) else begin
			value_errors++;
			$display("ERR %0t: ready low in the access phase of read %h", $time, addr);
		end
		apb_req <= '0;
	endtask

	task automatic check_read(input logic [7:0] addr, input logic [31:0] want,
			input logic want_err);
		logic [31:0] data;
		logic        err;
		apb_read(addr, data, err);
		assert (data == want && err == want_err) else begin
			value_errors++;
			$display("ERR %0t: read %h gave %h slverr %b, expected %h slverr %b",
				$time, addr, data, err, want, want_err);
		end
	endtask

	////////////////////////////////////////
	// Vertex driver and expected values
	////////////////////////////////////////

	task automatic send_vertex(input vertex_job_t job);
		int        idx;
		int        left;
		int        slot;
		int        cnt;
		int        cycles;
		logic      taken;
		read_cmd_t c;
		edge_job_t e;
		idx  = int'(job.edge_idx);
		left = int'(job.degree);
		while (left > 0) begin
			slot = idx % LINE_EDGES;
			cnt  = (left < LINE_EDGES - slot) ? left : LINE_EDGES - slot;
			c.address = (base_shadow + 32'(idx * EDGE_BYTES)) & ~32'(LINE_BYTES - 1);
			c.opcode  = ctrl_shadow[1] ? READ_SHARED : READ_NO_ALLOC;
			c.slot    = SLOT_W'(slot);
			c.count   = LCNT_W'(cnt);
			exp_cmds.push_back(c);
			idx  = idx + cnt;
			left = left - cnt;
		end
		for (int j = 0; j < int'(job.degree); j++) begin
			e.src  = job.id;
			e.dest = mem_model[word_index(base_shadow
				+ 32'((int'(job.edge_idx) + j) * EDGE_BYTES))];
			e.seq  = CNT_W'(j);
			exp_edges.push_back(e);
		end
		expected_total = expected_total + int'(job.degree);
		@(posedge clock);
		vertex_valid <= 1'b1;
		vertex_job   <= job;
		taken = 1'b0;
		for (cycles = 0; cycles < WAIT_LIMIT && !taken; cycles++) begin
			@(posedge clock);
			taken = vertex_ready;
		end
		vertex_valid <= 1'b0;
		if (!taken) begin
			other_failures++;
			$display("Timeout: vertex %h was never accepted", job.id);
			timed_out = 1'b1;
		end
	endtask

	// Waits until every expected edge has arrived, then checks status and count
	task automatic drain_check();
		int          cycles;
		int          polls;
		logic [31:0] data;
		logic        err;
		for (cycles = 0; cycles < WAIT_LIMIT
				&& (exp_edges.size() != 0 || exp_cmds.size() != 0); cycles++) begin
			@(posedge clock);
		end
		if (exp_edges.size() != 0 || exp_cmds.size() != 0) begin
			other_failures++;
			$display("Timeout: %0d edges and %0d commands never arrived",
				exp_edges.size(), exp_cmds.size());
			timed_out = 1'b1;
		end else begin
			data = 32'd1;
			for (polls = 0; polls < POLL_LIMIT && data[0]; polls++) begin
				apb_read(8'h0C, data, err);
			end
			if (data[0]) begin
				other_failures++;
				$display("Timeout: busy flag stayed set after the last vertex");
				timed_out = 1'b1;
			end else begin
				check_read(8'h08, 32'(expected_total), 1'b0);
			end
		end
	endtask

	////////////////////////////////////////
	// Memory model, back-pressure, checkers
	////////////////////////////////////////

	task automatic check_command(input read_cmd_t got);
		read_cmd_t want;
		assert (exp_cmds.size() != 0) else begin
			other_failures++;
			$display("Unexpected read command at %0t for address %h", $time, got.address);
		end
		if (exp_cmds.size() != 0) begin
			want = exp_cmds.pop_front();
			assert (got == want) else begin
				value_errors++;
				$display("ERR %0t: cmd %h op %0d slot %0d cnt %0d, expected %h op %0d slot %0d cnt %0d",
					$time, got.address, got.opcode, got.slot, got.count,
					want.address, want.opcode, want.slot, want.count);
			end
		end
	endtask

	task automatic check_edge(input edge_job_t got);
		edge_job_t want;
		assert (exp_edges.size() != 0) else begin
			other_failures++;
			$display("Unexpected edge job at %0t from source %h", $time, got.src);
		end
		if (exp_edges.size() != 0) begin
			want = exp_edges.pop_front();
			assert (got == want) else begin
				value_errors++;
				$display("ERR %0t: edge %h %h seq %0d, expected %h %h seq %0d",
					$time, got.src, got.dest, got.seq, want.src, want.dest, want.seq);
			end
		end
	endtask

	always @(posedge clock) begin
		rsp <= '0;
		if (rsp_pending) begin
			if (rsp_delay == 0) begin
				rsp <= line_response(held_cmd);
				rsp_pending = 1'b0;
			end else begin
				rsp_delay = rsp_delay - 1;
			end
		end
		if (rstn && cmd_valid && cmd_ready) begin
			check_command(cmd);
			held_cmd    = cmd;
			rsp_pending = 1'b1;
			rsp_delay   = 2 * int'(random_bit());
			rsp_delay   = rsp_delay + int'(random_bit());
		end
		cmd_ready  <= random_bit();
		edge_ready <= random_bit();
	end

	always @(posedge clock) begin
		if (rstn && edge_valid && edge_ready) begin
			check_edge(edge_job);
		end
	end

	////////////////////////////////////////
	// Record sequencer
	////////////////////////////////////////

	initial begin
		int   p;
		int   cycles;
		logic done;
		apb_req      = '0;
		vertex_valid = 1'b0;
		vertex_job   = '0;
		p    = 0;
		done = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_model[i] = 32'hC0DE_0000 ^ (32'(i) * 32'h0001_0003);
		end
		for (int i = 0; i < STIM_WORDS; i++) begin
			stim[i] = '0;
		end
		$readmemh("tests/edge_fetch_tests.txt", stim);
		for (cycles = 0; cycles < 50 && !rstn; cycles++) begin
			@(posedge clock);
		end
		if (!rstn) begin
			other_failures++;
			$display("Timeout: reset was never released");
			timed_out = 1'b1;
		end else begin
			assert (!vertex_ready && !cmd_valid && !edge_valid) else begin
				value_errors++;
				$display("ERR %0t: handshake outputs high after reset", $time);
			end
		end
		while (!done && !timed_out) begin
			if (p > STIM_WORDS - 4) begin
				done = 1'b1;
			end else begin
				case (stim[p])
					32'd0: done = 1'b1;
					32'd1: begin
						mem_model[word_index(stim[p+1])] = stim[p+2];
						p = p + 3;
					end
					32'd2: begin
						apb_write(stim[p+1][7:0], stim[p+2]);
						if (stim[p+1][7:0] == 8'h00) ctrl_shadow = stim[p+2];
						if (stim[p+1][7:0] == 8'h04) base_shadow = stim[p+2];
						if (stim[p+1][7:0] == 8'h08) expected_total = 0;
						p = p + 3;
					end
					32'd3: begin
						check_read(stim[p+1][7:0], stim[p+2], stim[p+3][0]);
						p = p + 4;
					end
					32'd4: begin
						send_vertex('{id: stim[p+1], edge_idx: stim[p+2],
							degree: stim[p+3][CNT_W-1:0]});
						p = p + 4;
					end
					32'd5: begin
						drain_check();
						p = p + 1;
					end
					default: begin
						other_failures++;
						$display("Unknown record kind %h at word %0d of the data file", stim[p], p);
						done = 1'b1;
					end
				endcase
			end
		end
		$display("Checks done: %0d wrong values, %0d other failures",
			value_errors, other_failures);
		if (value_errors == 0 && other_failures == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/edge_fetch_tests.txt
// Kinds: 1 memory byte_addr word | 2 apb write addr data | 3 apb read addr expect slverr
// 4 vertex id edge_idx degree | 5 drain, check STATUS and EDGE_COUNT | 0 end
3 00 00000000 0
3 04 00000000 0
3 08 00000000 0
3 0C 00000000 0
3 10 00000000 1
2 04 00000100
3 04 00000100 0
2 00 00000001
3 00 00000001 0
1 00000118 5A5A0006
1 00000120 5A5A0008
4 00000011 00000000 00000008
5
4 00000022 00000006 00000007
5
2 00 00000003
3 00 00000003 0
4 00000033 00000010 00000005
4 00000044 00000020 00000000
4 00000055 00000015 0000000B
5
2 08 00000000
3 08 00000000 0
4 00000066 00000023 00000018
4 00000077 00000040 00000003
5
0

//--- compile.f
source/edge_fetch_pkg.sv
source/edge_fetch_regs.sv
source/edge_read_sequencer.sv
source/edge_line_unpacker.sv
source/edge_job_fifo.sv
source/edge_fetch_top.sv
tests/tb_clock_gen.sv
tests/edge_fetch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f compile.f \
	--top-module edge_fetch_tb -o sim_edge_fetch
output=$(./obj_dir/sim_edge_fetch)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Regression passed"
